/* source/interp_defs.svh */
`ifndef INTERP_DEFS_SVH
`define INTERP_DEFS_SVH

// Reply word for the ping command
`define INTERP_ID 32'h7700006A

// Length of the core reset sequence in clock cycles
`define RESET_CLK_CYCLES 20

// Command word layout
`define WORD_BITS    32
`define OPCODE_BITS  8
`define OPERAND_BITS 24

// Datapath widths
`define ACC_BITS     64
`define ADDR_BITS    32
`define CYCLE_BITS   32

`endif

/* source/cmd_pkg.sv */
`include "interp_defs.svh"

package cmd_pkg;

    // ASCII opcodes in bits 7:0 of a command word
    typedef enum logic [`OPCODE_BITS-1:0] {
        OP_WRITE_CLK    = 8'h43, // C
        OP_STOP_CLK     = 8'h53, // S
        OP_RESUME_CLK   = 8'h72, // r
        OP_RESET_CORE   = 8'h52, // R
        OP_WRITE_MEM    = 8'h57, // W
        OP_READ_MEM     = 8'h4C, // L
        OP_LOAD_UPPER   = 8'h55, // U
        OP_LOAD_LOWER   = 8'h6C, // l
        OP_ADD_ACC      = 8'h41, // A
        OP_WRITE_ACC_N  = 8'h77, // w
        OP_WRITE_N_ACC  = 8'h73, // s
        OP_READ_ACC_POS = 8'h47, // G
        OP_PING         = 8'h70, // p
        OP_GET_ACC      = 8'h61  // a
    } opcode_t;

    // Operand field, bits 31:8 of a command word
    typedef logic [`OPERAND_BITS-1:0] operand_t;

endpackage

/* source/bus_pkg.sv */
`include "interp_defs.svh"

package bus_pkg;

    // UART and memory data word
    typedef logic [`WORD_BITS-1:0] word_t;

    // Byte address on the memory bus
    typedef logic [`ADDR_BITS-1:0] addr_t;

    // Command accumulator
    typedef logic [`ACC_BITS-1:0] acc_t;

    // Number of core clock pulses
    typedef logic [`CYCLE_BITS-1:0] cycles_t;

endpackage

/* source/cmd_fetch.sv */
`timescale 1ns/100ps

module cmd_fetch import bus_pkg::*; (
    input  logic  clk,
    input  logic  reset,

    input  logic  uart_rx_empty,
    output logic  uart_read,
    input  logic  uart_read_response,
    input  word_t uart_read_data,

    output logic  word_valid,
    output word_t word_data,
    input  logic  word_ready
);

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_READING,
        FETCH_HOLDING
    } fetch_state_t;

    fetch_state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH_IDLE;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (!uart_rx_empty) begin
                        state <= FETCH_READING;
                    end
                end
                FETCH_READING: begin
                    if (uart_read_response) begin // Buffer delivers the word now
                        state <= FETCH_HOLDING;
                    end
                end
                FETCH_HOLDING: begin
                    if (word_ready) begin
                        state <= FETCH_IDLE;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH_READING && uart_read_response) begin
            word_data <= uart_read_data;
        end
    end

    assign uart_read  = (state == FETCH_READING); // Held until the response
    assign word_valid = (state == FETCH_HOLDING);

endmodule

/* source/cmd_exec.sv */
`timescale 1ns/100ps
`include "interp_defs.svh"

module cmd_exec import cmd_pkg::*, bus_pkg::*; (
    input  logic    clk,
    input  logic    reset,

    input  logic    word_valid,
    input  word_t   word_data,
    output logic    word_ready,

    output logic    reply_valid,
    output word_t   reply_data,
    input  logic    reply_ready,

    output logic    mem_read,
    output logic    mem_write,
    output addr_t   mem_addr,
    output word_t   mem_write_data,
    input  word_t   mem_read_data,
    input  logic    memory_response,

    output logic    core_clk_enable,
    output logic    core_reset,
    output cycles_t cycles_to_pulse,
    output logic    write_pulse
);

    typedef enum logic [2:0] {
        EXEC_IDLE,
        EXEC_DATA,
        EXEC_READ_WAIT,
        EXEC_WRITE_WAIT,
        EXEC_REPLY,
        EXEC_RESET
    } exec_state_t;

    exec_state_t state;
    acc_t        acc;
    cycles_t     reset_count;
    opcode_t     opcode;
    operand_t    operand;
    acc_t        operand_sext;

    assign opcode  = opcode_t'(word_data[`OPCODE_BITS-1:0]);
    assign operand = word_data[`WORD_BITS-1:`OPCODE_BITS];
    assign operand_sext = {{(`ACC_BITS-`OPERAND_BITS){operand[`OPERAND_BITS-1]}}, operand};

    assign word_ready  = (state == EXEC_IDLE) || (state == EXEC_DATA);
    assign reply_valid = (state == EXEC_REPLY);

    always_ff @(posedge clk) begin
        mem_read    <= 1'b0;
        mem_write   <= 1'b0;
        write_pulse <= 1'b0;

        if (reset) begin
            state           <= EXEC_IDLE;
            acc             <= '0;
            reset_count     <= '0;
            core_clk_enable <= 1'b0;
            core_reset      <= 1'b0;
        end else begin
            case (state)
                EXEC_IDLE: begin
                    if (word_valid) begin
                        case (opcode)
                            OP_WRITE_CLK: begin
                                core_clk_enable <= 1'b1;
                                cycles_to_pulse <= cycles_t'(operand);
                                write_pulse     <= 1'b1;
                            end
                            OP_STOP_CLK:   core_clk_enable <= 1'b0;
                            OP_RESUME_CLK: core_clk_enable <= 1'b1;
                            OP_RESET_CORE: begin
                                core_reset      <= 1'b1;
                                core_clk_enable <= 1'b1;
                                cycles_to_pulse <= cycles_t'(`RESET_CLK_CYCLES);
                                write_pulse     <= 1'b1;
                                reset_count     <= cycles_t'(1); // First high cycle
                                state           <= EXEC_RESET;
                            end
                            OP_WRITE_MEM: begin
                                mem_addr <= addr_t'(operand);
                                state    <= EXEC_DATA; // Data word follows
                            end
                            OP_READ_MEM: begin
                                mem_addr <= addr_t'(operand);
                                mem_read <= 1'b1;
                                state    <= EXEC_READ_WAIT;
                            end
                            OP_READ_ACC_POS: begin
                                mem_addr <= acc[`ADDR_BITS-1:0];
                                mem_read <= 1'b1;
                                state    <= EXEC_READ_WAIT;
                            end
                            OP_WRITE_ACC_N: begin
                                mem_addr       <= addr_t'(operand);
                                mem_write_data <= acc[`WORD_BITS-1:0];
                                mem_write      <= 1'b1;
                                state          <= EXEC_WRITE_WAIT;
                            end
                            OP_WRITE_N_ACC: begin
                                mem_addr       <= acc[`ADDR_BITS-1:0];
                                mem_write_data <= word_t'(operand);
                                mem_write      <= 1'b1;
                                state          <= EXEC_WRITE_WAIT;
                            end
                            OP_LOAD_UPPER: begin
                                acc <= {{(`ACC_BITS-`OPERAND_BITS-8){1'b0}}, operand, acc[7:0]};
                            end
                            OP_LOAD_LOWER: acc <= {acc[`ACC_BITS-1:8], operand[7:0]};
                            OP_ADD_ACC:    acc <= acc + operand_sext;
                            OP_PING: begin
                                reply_data <= `INTERP_ID;
                                state      <= EXEC_REPLY;
                            end
                            OP_GET_ACC: begin
                                reply_data <= acc[`WORD_BITS-1:0];
                                state      <= EXEC_REPLY;
                            end
                            default: state <= EXEC_IDLE; // Unknown opcode dropped
                        endcase
                    end
                end
                EXEC_DATA: begin
                    if (word_valid) begin
                        mem_write_data <= word_data;
                        mem_write      <= 1'b1;
                        state          <= EXEC_WRITE_WAIT;
                    end
                end
                EXEC_READ_WAIT: begin
                    if (memory_response) begin
                        reply_data <= mem_read_data;
                        state      <= EXEC_REPLY;
                    end
                end
                EXEC_WRITE_WAIT: begin
                    if (memory_response) begin
                        state <= EXEC_IDLE;
                    end
                end
                EXEC_REPLY: begin
                    if (reply_ready) begin
                        state <= EXEC_IDLE;
                    end
                end
                EXEC_RESET: begin
                    if (reset_count == cycles_t'(`RESET_CLK_CYCLES)) begin
                        core_reset      <= 1'b0;
                        core_clk_enable <= 1'b0; // Core stays halted after reset
                        state           <= EXEC_IDLE;
                    end else begin
                        reset_count <= reset_count + 1'b1;
                    end
                end
                default: state <= EXEC_IDLE;
            endcase
        end
    end

endmodule

/* source/reply_send.sv */
`timescale 1ns/100ps

module reply_send import bus_pkg::*; (
    input  logic  clk,
    input  logic  reset,

    input  logic  reply_valid,
    input  word_t reply_data,
    output logic  reply_ready,

    output logic  uart_write,
    output word_t uart_write_data,
    input  logic  uart_write_response
);

    typedef enum logic {
        SEND_IDLE,
        SEND_WAIT
    } send_state_t;

    send_state_t state;

    always_ff @(posedge clk) begin
        uart_write <= 1'b0;

        if (reset) begin
            state <= SEND_IDLE;
        end else begin
            case (state)
                SEND_IDLE: begin
                    if (reply_valid) begin
                        uart_write <= 1'b1; // Single cycle strobe
                        state      <= SEND_WAIT;
                    end
                end
                SEND_WAIT: begin
                    if (uart_write_response) begin
                        state <= SEND_IDLE;
                    end
                end
                default: state <= SEND_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reply_valid && reply_ready) begin
            uart_write_data <= reply_data;
        end
    end

    assign reply_ready = (state == SEND_IDLE);

endmodule

/* source/debug_interpreter.sv */
`timescale 1ns/100ps

module debug_interpreter import bus_pkg::*; (
    input  logic    clk,
    input  logic    reset,

    input  logic    uart_rx_empty,
    output logic    uart_read,
    input  logic    uart_read_response,
    input  word_t   uart_read_data,

    output logic    uart_write,
    output word_t   uart_write_data,
    input  logic    uart_write_response,

    output logic    mem_read,
    output logic    mem_write,
    output addr_t   mem_addr,
    output word_t   mem_write_data,
    input  word_t   mem_read_data,
    input  logic    memory_response,

    output logic    core_clk_enable,
    output logic    core_reset,
    output cycles_t cycles_to_pulse,
    output logic    write_pulse
);

    logic  word_valid;
    word_t word_data;
    logic  word_ready;
    logic  reply_valid;
    word_t reply_data;
    logic  reply_ready;

    cmd_fetch i_cmd_fetch (
        .clk                (clk),
        .reset              (reset),
        .uart_rx_empty      (uart_rx_empty),
        .uart_read          (uart_read),
        .uart_read_response (uart_read_response),
        .uart_read_data     (uart_read_data),
        .word_valid         (word_valid),
        .word_data          (word_data),
        .word_ready         (word_ready)
    );

    cmd_exec i_cmd_exec (
        .clk             (clk),
        .reset           (reset),
        .word_valid      (word_valid),
        .word_data       (word_data),
        .word_ready      (word_ready),
        .reply_valid     (reply_valid),
        .reply_data      (reply_data),
        .reply_ready     (reply_ready),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_addr        (mem_addr),
        .mem_write_data  (mem_write_data),
        .mem_read_data   (mem_read_data),
        .memory_response (memory_response),
        .core_clk_enable (core_clk_enable),
        .core_reset      (core_reset),
        .cycles_to_pulse (cycles_to_pulse),
        .write_pulse     (write_pulse)
    );

    reply_send i_reply_send (
        .clk                 (clk),
        .reset               (reset),
        .reply_valid         (reply_valid),
        .reply_data          (reply_data),
        .reply_ready         (reply_ready),
        .uart_write          (uart_write),
        .uart_write_data     (uart_write_data),
        .uart_write_response (uart_write_response)
    );

endmodule

/* sim/tb_harness_models.sv */
`timescale 1ns/100ps

module tb_harness_models import bus_pkg::*; (
    input  logic  clk,
    input  logic  reset,

    output logic  uart_rx_empty,
    input  logic  uart_read,
    output logic  uart_read_response,
    output word_t uart_read_data,

    input  logic  uart_write,
    input  word_t uart_write_data,
    output logic  uart_write_response,

    input  logic  mem_read,
    input  logic  mem_write,
    input  addr_t mem_addr,
    input  word_t mem_write_data,
    output word_t mem_read_data,
    output logic  memory_response
);

    word_t       rx_fifo [0:63];
    int          rx_wr = 0;
    int          rx_rd = 0;
    word_t       tx_log [0:63];
    int          tx_count = 0;
    logic        tx_slow = 1'b0; // Stretches the transmitter response
    word_t       mem [addr_t];
    int          write_count = 0;
    int          read_count = 0;
    addr_t       last_write_addr;
    word_t       last_write_data;
    logic [31:0] rnd_state = 32'd30;
    int          rx_delay;
    int          tx_delay;
    int          mem_delay;
    logic        tx_busy;
    logic        mem_busy;
    logic        mem_is_read;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int next_delay();
        rnd_state = xorshift(rnd_state);
        return int'(rnd_state % 4);
    endfunction

    function automatic word_t fill_word(input addr_t a);
        return a ^ 32'hA5C3_0F96; // Unwritten locations
    endfunction

    task automatic push_rx(input word_t w);
        rx_fifo[rx_wr % 64] = w;
        rx_wr = rx_wr + 1;
    endtask

    initial begin
        uart_rx_empty       = 1'b1;
        uart_read_response  = 1'b0;
        uart_read_data      = '0;
        uart_write_response = 1'b0;
        mem_read_data       = '0;
        memory_response     = 1'b0;
    end

    always @(negedge clk) begin
        if (reset) begin
            rx_delay = next_delay();
            tx_busy  = 1'b0;
            mem_busy = 1'b0;
            uart_read_response  = 1'b0;
            uart_write_response = 1'b0;
            memory_response     = 1'b0;
        end else begin
            if (uart_read_response) begin
                uart_read_response = 1'b0;
            end else if (uart_read && rx_rd != rx_wr) begin
                if (rx_delay == 0) begin
                    uart_read_data     = rx_fifo[rx_rd % 64];
                    rx_rd              = rx_rd + 1;
                    uart_read_response = 1'b1;
                    rx_delay           = next_delay();
                end else begin
                    rx_delay = rx_delay - 1;
                end
            end

            if (uart_write_response) begin
                uart_write_response = 1'b0;
            end else if (tx_busy) begin
                if (tx_delay == 0) begin
                    uart_write_response = 1'b1;
                    tx_busy             = 1'b0;
                end else begin
                    tx_delay = tx_delay - 1;
                end
            end
            if (uart_write) begin
                tx_log[tx_count % 64] = uart_write_data;
                tx_count = tx_count + 1;
                tx_delay = tx_slow ? 12 + next_delay() : next_delay();
                tx_busy  = 1'b1;
            end

            if (memory_response) begin
                memory_response = 1'b0;
            end else if (mem_busy) begin
                if (mem_delay == 0) begin
                    if (mem_is_read) begin
                        mem_read_data = mem.exists(mem_addr) ? mem[mem_addr] : fill_word(mem_addr);
                        read_count    = read_count + 1;
                    end else begin
                        mem[mem_addr]   = mem_write_data;
                        last_write_addr = mem_addr;
                        last_write_data = mem_write_data;
                        write_count     = write_count + 1;
                    end
                    memory_response = 1'b1;
                    mem_busy        = 1'b0;
                end else begin
                    mem_delay = mem_delay - 1;
                end
            end else if (mem_read || mem_write) begin
                mem_is_read = mem_read;
                mem_delay   = next_delay();
                mem_busy    = 1'b1;
            end

            uart_rx_empty = (rx_rd == rx_wr);
        end
    end

endmodule

/* sim/tb_debug_interpreter.sv */
`timescale 1ns/100ps
`include "interp_defs.svh"

module tb_debug_interpreter import cmd_pkg::*, bus_pkg::*; ();

    localparam int NUM_CMDS    = 40;
    localparam int WORST_CYCLE = 60; // Slow transmitter plus reset sequence
    localparam int MARGIN      = 4;

    logic    clk = 1'b0;
    logic    reset = 1'b1;
    logic    uart_rx_empty, uart_read, uart_read_response;
    word_t   uart_read_data, uart_write_data, mem_write_data, mem_read_data;
    logic    uart_write, uart_write_response, mem_read, mem_write, memory_response;
    addr_t   mem_addr;
    logic    core_clk_enable, core_reset, write_pulse;
    cycles_t cycles_to_pulse;

    acc_t    exp_acc = '0;
    int      pulse_count = 0;
    cycles_t last_pulse_cycles;
    int      reset_run = 0;
    int      last_reset_len = 0;
    int      reset_seqs = 0;

    debug_interpreter i_debug_interpreter (.*);

    tb_harness_models i_models (.*);

    initial begin
        forever #4 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            report_failure($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    function automatic word_t make_cmd(input opcode_t op, input operand_t operand);
        return {operand, op};
    endfunction

    task automatic send_cmd(input opcode_t op, input operand_t operand);
        i_models.push_rx(make_cmd(op, operand));
        if (op == OP_LOAD_UPPER) exp_acc = ({40'd0, operand} << 8) | {56'd0, exp_acc[7:0]};
        if (op == OP_LOAD_LOWER) exp_acc = {exp_acc[63:8], operand[7:0]};
        if (op == OP_ADD_ACC) exp_acc = exp_acc + {{40{operand[23]}}, operand};
    endtask

    task automatic wait_replies(input int total);
        while (i_models.tx_count < total) @(negedge clk);
    endtask

    task automatic expect_reply(input opcode_t op, input operand_t operand, input word_t exp);
        int base;
        base = i_models.tx_count;
        send_cmd(op, operand);
        wait_replies(base + 1);
        check_value("uart_write_data", 64'(i_models.tx_log[base % 64]), 64'(exp));
    endtask

    task automatic expect_write(input word_t cmd, input addr_t addr, input word_t data);
        int base;
        base = i_models.write_count;
        i_models.push_rx(cmd);
        while (i_models.write_count == base) @(negedge clk);
        check_value("mem_addr", 64'(i_models.last_write_addr), 64'(addr));
        check_value("mem_write_data", 64'(i_models.last_write_data), 64'(data));
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            if (write_pulse) begin
                pulse_count       <= pulse_count + 1;
                last_pulse_cycles <= cycles_to_pulse;
            end
            if (core_reset) begin
                assert (core_clk_enable) else report_failure("Core clock disabled during reset");
                reset_run <= reset_run + 1;
            end else if (reset_run != 0) begin
                last_reset_len <= reset_run;
                reset_seqs     <= reset_seqs + 1;
                reset_run      <= 0;
            end
        end
    end

    initial begin
        #(NUM_CMDS * WORST_CYCLE * MARGIN * 8);
        report_failure("Watchdog expired before the tests completed");
    end

    initial begin
        int base;
        int pulses;
        int writes;
        int reads;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        check_value("core_clk_enable", 64'(core_clk_enable), 64'h0);
        check_value("core_reset", 64'(core_reset), 64'h0);
        check_value("uart_read", 64'(uart_read), 64'h0);
        check_value("uart_write", 64'(uart_write), 64'h0);
        check_value("mem_read", 64'(mem_read), 64'h0);
        check_value("mem_write", 64'(mem_write), 64'h0);
        check_value("write_pulse", 64'(write_pulse), 64'h0);

        expect_reply(OP_PING, '0, `INTERP_ID);
        expect_reply(OP_GET_ACC, '0, exp_acc[31:0]); // Cleared by reset

        send_cmd(OP_LOAD_UPPER, 24'h123456);
        send_cmd(OP_LOAD_LOWER, 24'h0000AB);
        send_cmd(OP_ADD_ACC, 24'hFFFFFB); // Minus five
        expect_reply(OP_GET_ACC, '0, exp_acc[31:0]);

        send_cmd(OP_WRITE_MEM, 24'h000300);
        expect_write(32'hCAFE_F00D, 32'h300, 32'hCAFE_F00D); // Data word
        expect_reply(OP_READ_MEM, 24'h000300, 32'hCAFE_F00D);

        send_cmd(OP_LOAD_UPPER, 24'h000010);
        send_cmd(OP_LOAD_LOWER, 24'h000040);
        expect_write(make_cmd(OP_WRITE_ACC_N, 24'h000200), 32'h200, exp_acc[31:0]);
        expect_write(make_cmd(OP_WRITE_N_ACC, 24'h00BEEF), exp_acc[31:0], 32'h0000BEEF);
        expect_reply(OP_READ_ACC_POS, '0, 32'h0000BEEF);
        check_value("mem", 64'(i_models.mem[exp_acc[31:0]]), 64'h0000BEEF);

        pulses = pulse_count;
        send_cmd(OP_RESET_CORE, '0);
        while (reset_seqs == 0) @(negedge clk);
        check_value("core_reset length", 64'(last_reset_len), 64'(`RESET_CLK_CYCLES));
        check_value("core_clk_enable", 64'(core_clk_enable), 64'h0);
        check_value("core_reset", 64'(core_reset), 64'h0);
        check_value("write_pulse count", 64'(pulse_count), 64'(pulses + 1));
        check_value("cycles_to_pulse", 64'(last_pulse_cycles), 64'(`RESET_CLK_CYCLES));

        pulses = pulse_count;
        send_cmd(OP_WRITE_CLK, 24'h000123);
        while (pulse_count == pulses) @(negedge clk);
        check_value("cycles_to_pulse", 64'(last_pulse_cycles), 64'h123);
        check_value("core_clk_enable", 64'(core_clk_enable), 64'h1);
        send_cmd(OP_STOP_CLK, '0);
        expect_reply(OP_PING, '0, `INTERP_ID);
        check_value("core_clk_enable", 64'(core_clk_enable), 64'h0);
        send_cmd(OP_RESUME_CLK, '0);
        expect_reply(OP_PING, '0, `INTERP_ID);
        check_value("core_clk_enable", 64'(core_clk_enable), 64'h1);

        pulses = pulse_count;
        writes = i_models.write_count;
        reads  = i_models.read_count;
        base   = i_models.tx_count;
        i_models.push_rx(32'h0012_34FF); // Opcode outside the command set
        expect_reply(OP_PING, '0, `INTERP_ID);
        check_value("reply count", 64'(i_models.tx_count), 64'(base + 1));
        check_value("write_pulse count", 64'(pulse_count), 64'(pulses));
        check_value("memory writes", 64'(i_models.write_count), 64'(writes));
        check_value("memory reads", 64'(i_models.read_count), 64'(reads));

        i_models.tx_slow = 1'b1;
        base = i_models.tx_count;
        for (int i = 0; i < 6; i++) begin
            send_cmd(OP_PING, operand_t'(i));
        end
        wait_replies(base + 6);
        for (int i = 0; i < 6; i++) begin
            check_value("uart_write_data", 64'(i_models.tx_log[(base + i) % 64]),
                        64'(`INTERP_ID));
        end

        repeat (30) @(negedge clk);
        check_value("reply count", 64'(i_models.tx_count), 64'(base + 6));
        $display("All tests passed!");
        $finish;
    end

endmodule

/* debug_interpreter.f */
+incdir+source
source/cmd_pkg.sv
source/bus_pkg.sv
source/cmd_fetch.sv
source/cmd_exec.sv
source/reply_send.sv
source/debug_interpreter.sv
sim/tb_harness_models.sv
sim/tb_debug_interpreter.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_debug_interpreter \
    -f debug_interpreter.f \
    -o sim_debug_interpreter
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/sim_debug_interpreter
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed"
    exit $status
fi

exit 0
